// ==== source/cmd_pkg.sv ====
// Shared widths, memory sizes and command encodings of the command parser
package cmd_pkg;

    // stream and word sizes
    localparam int byte_w    = 8;
    localparam int word_w    = 16;

    // block RAM geometry
    localparam int ram_depth = 256;
    localparam int ram_aw    = 8;

    // opcodes 4 and 5 are reserved and decode as unknown
    typedef enum logic [byte_w-1:0] {
        op_disable   = 8'd0,
        op_enable    = 8'd1,
        op_write_reg = 8'd2,
        op_read_reg  = 8'd3,
        op_write_ram = 8'd6,
        op_read_ram  = 8'd7
    } opcode_e;

    // user register map
    typedef enum logic [byte_w-1:0] {
        reg_sum  = 8'd0,
        reg_num1 = 8'd1,
        reg_num2 = 8'd2,
        reg_num3 = 8'd3,
        reg_en   = 8'd4
    } reg_addr_e;

endpackage

// ==== source/cmd_if.sv ====
// Command item channel from the frame parser to the command executor
`timescale 1ns/1ps

interface cmd_if;

    logic                       valid;
    logic                       ready;
    cmd_pkg::opcode_e           op;
    logic [cmd_pkg::word_w-1:0] addr;
    logic [cmd_pkg::word_w-1:0] data;

    // parser side
    modport source (
        output valid,
        output op,
        output addr,
        output data,
        input  ready
    );

    // executor side
    modport sink (
        input  valid,
        input  op,
        input  addr,
        input  data,
        output ready
    );

endinterface

// ==== source/word_ram.sv ====
// Single-port word RAM with synchronous write and registered read
`timescale 1ns/1ps

module word_ram (
    input  logic                        clk,
    input  logic                        we,
    input  logic [cmd_pkg::ram_aw-1:0]  waddr,
    input  logic [cmd_pkg::word_w-1:0]  wdata,
    input  logic [cmd_pkg::ram_aw-1:0]  raddr,
    output logic [cmd_pkg::word_w-1:0]  rdata
);

    logic [cmd_pkg::word_w-1:0] mem [cmd_pkg::ram_depth];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // old data on a same-address collision
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== source/frame_parser.sv ====
// Frame parser that assembles opcode, address, count and data bytes into command items
`timescale 1ns/1ps

module frame_parser (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rx_valid,
    input  logic [cmd_pkg::byte_w-1:0]  rx_data,
    output logic                        rx_ready,
    cmd_if.source                       cmd
);

    typedef enum logic [2:0] {
        ph_idle,
        ph_addr,
        ph_count,
        ph_data_lo,
        ph_data_hi,
        ph_emit
    } phase_e;

    localparam int bw = cmd_pkg::byte_w;
    localparam int ww = cmd_pkg::word_w;

    phase_e             phase;
    phase_e             phase_d;
    cmd_pkg::opcode_e   op_q;
    logic [ww-1:0]      addr_q;
    logic [ww-1:0]      data_q;
    logic [ww-1:0]      count_q;
    logic               hi_byte;
    logic               rx_fire;
    logic               item_fire;
    logic               is_ram;

    assign rx_fire   = rx_valid && rx_ready;
    assign item_fire = cmd.valid && cmd.ready;
    assign is_ram    = (op_q == cmd_pkg::op_write_ram) || (op_q == cmd_pkg::op_read_ram);

    assign cmd.valid = (phase == ph_emit);
    assign cmd.op    = op_q;
    assign cmd.addr  = addr_q;
    assign cmd.data  = data_q;

    always_comb begin
        phase_d = phase;
        case (phase)
            ph_idle: begin
                if (rx_fire) begin
                    case (rx_data)
                        cmd_pkg::op_disable,
                        cmd_pkg::op_enable:    phase_d = ph_emit;
                        cmd_pkg::op_write_reg,
                        cmd_pkg::op_read_reg,
                        cmd_pkg::op_write_ram,
                        cmd_pkg::op_read_ram:  phase_d = ph_addr;
                        default:               phase_d = ph_idle;
                    endcase
                end
            end
            ph_addr: begin
                if (rx_fire) begin
                    if (!is_ram)
                        phase_d = (op_q == cmd_pkg::op_read_reg) ? ph_emit : ph_data_lo;
                    else if (hi_byte)
                        phase_d = ph_count;
                end
            end
            ph_count: begin
                // empty block ends the frame here
                if (rx_fire && hi_byte) begin
                    if ({rx_data, count_q[bw-1:0]} == '0)
                        phase_d = ph_idle;
                    else if (op_q == cmd_pkg::op_write_ram)
                        phase_d = ph_data_lo;
                    else
                        phase_d = ph_emit;
                end
            end
            ph_data_lo: begin
                if (rx_fire)
                    phase_d = ph_data_hi;
            end
            ph_data_hi: begin
                if (rx_fire)
                    phase_d = ph_emit;
            end
            ph_emit: begin
                if (item_fire) begin
                    if (!is_ram || count_q == ww'(1))
                        phase_d = ph_idle;
                    else if (op_q == cmd_pkg::op_write_ram)
                        phase_d = ph_data_lo;
                end
            end
            default: phase_d = ph_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= ph_idle;
            rx_ready <= 1'b0;
            op_q     <= cmd_pkg::op_disable;
            hi_byte  <= 1'b0;
            count_q  <= '0;
        end else begin
            phase    <= phase_d;
            rx_ready <= (phase_d != ph_emit);
            if (phase == ph_idle && rx_fire)
                op_q <= cmd_pkg::opcode_e'(rx_data);
            // low/high byte toggle for two-byte fields
            if (rx_fire && (phase == ph_addr || phase == ph_count))
                hi_byte <= is_ram && !hi_byte;
            if (rx_fire && phase == ph_count) begin
                if (hi_byte)
                    count_q[ww-1:bw] <= rx_data;
                else
                    count_q[bw-1:0] <= rx_data;
            end else if (item_fire && is_ram) begin
                count_q <= count_q - ww'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_fire) begin
            case (phase)
                ph_addr: begin
                    if (!is_ram)
                        addr_q <= {{(ww-bw){1'b0}}, rx_data};
                    else if (hi_byte)
                        addr_q[ww-1:bw] <= rx_data;
                    else
                        addr_q[bw-1:0] <= rx_data;
                end
                ph_data_lo: data_q[bw-1:0] <= rx_data;
                ph_data_hi: data_q[ww-1:bw] <= rx_data;
                default: ;
            endcase
        end else if (item_fire && is_ram) begin
            addr_q <= addr_q + ww'(1);
        end
    end

    // a stalled item keeps its fields and blocks the input stream
    a_item_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cmd.valid && !cmd.ready |=> cmd.valid && !rx_ready
            && $stable(cmd.addr) && $stable(cmd.data));

endmodule

// ==== source/cmd_executor.sv ====
// Command executor with the user registers, enable flag and block RAM access
`timescale 1ns/1ps

module cmd_executor (
    input  logic                        clk,
    input  logic                        rst_n,
    cmd_if.sink                         cmd,
    output logic                        resp_valid,
    output logic [cmd_pkg::word_w-1:0]  resp_data,
    input  logic                        resp_ready,
    input  logic [cmd_pkg::word_w-1:0]  sum,
    output logic [cmd_pkg::word_w-1:0]  num1,
    output logic [cmd_pkg::word_w-1:0]  num2,
    output logic [cmd_pkg::word_w-1:0]  num3,
    output logic                        en
);

    localparam int ww = cmd_pkg::word_w;
    localparam int aw = cmd_pkg::ram_aw;

    cmd_pkg::reg_addr_e reg_sel;
    logic               item_fire;
    logic               in_range;
    logic [ww-1:0]      reg_rd;
    logic [ww-1:0]      reg_rd_q;
    logic               from_ram_q;
    logic               ram_ok_q;
    logic               ram_we;
    logic [aw-1:0]      ram_raddr;
    logic [aw-1:0]      raddr_q;
    logic [ww-1:0]      ram_rdata;

    // no new item while a read response waits
    assign cmd.ready = !resp_valid;
    assign item_fire = cmd.valid && cmd.ready;
    assign reg_sel   = cmd_pkg::reg_addr_e'(cmd.addr[cmd_pkg::byte_w-1:0]);
    assign in_range  = cmd.addr < ww'(cmd_pkg::ram_depth);

    always_comb begin
        case (reg_sel)
            cmd_pkg::reg_sum:  reg_rd = sum;
            cmd_pkg::reg_num1: reg_rd = num1;
            cmd_pkg::reg_num2: reg_rd = num2;
            cmd_pkg::reg_num3: reg_rd = num3;
            cmd_pkg::reg_en:   reg_rd = {{(ww-1){1'b0}}, en};
            default:           reg_rd = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num1 <= '0;
            num2 <= '0;
            num3 <= '0;
            en   <= 1'b0;
        end else if (item_fire) begin
            case (cmd.op)
                cmd_pkg::op_disable: en <= 1'b0;
                cmd_pkg::op_enable:  en <= 1'b1;
                cmd_pkg::op_write_reg: begin
                    case (reg_sel)
                        cmd_pkg::reg_num1: num1 <= cmd.data;
                        cmd_pkg::reg_num2: num2 <= cmd.data;
                        cmd_pkg::reg_num3: num3 <= cmd.data;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            from_ram_q <= 1'b0;
            ram_ok_q   <= 1'b0;
        end else if (item_fire && (cmd.op == cmd_pkg::op_read_reg
                                   || cmd.op == cmd_pkg::op_read_ram)) begin
            resp_valid <= 1'b1;
            from_ram_q <= (cmd.op == cmd_pkg::op_read_ram);
            ram_ok_q   <= in_range;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    // read address held so the RAM output stays put under back-pressure
    assign ram_raddr = (item_fire && cmd.op == cmd_pkg::op_read_ram)
                     ? cmd.addr[aw-1:0] : raddr_q;
    assign ram_we    = item_fire && (cmd.op == cmd_pkg::op_write_ram) && in_range;

    always_ff @(posedge clk) begin
        raddr_q <= ram_raddr;
        if (item_fire && cmd.op == cmd_pkg::op_read_reg)
            reg_rd_q <= reg_rd;
    end

    // out of range reads give 0
    assign resp_data = from_ram_q ? (ram_ok_q ? ram_rdata : '0) : reg_rd_q;

    word_ram u_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (cmd.addr[aw-1:0]),
        .wdata (cmd.data),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data));

endmodule

// ==== source/word_serializer.sv ====
// Word serializer that sends each read word as two bytes, low byte first
`timescale 1ns/1ps

module word_serializer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        resp_valid,
    input  logic [cmd_pkg::word_w-1:0]  resp_data,
    output logic                        resp_ready,
    output logic                        tx_valid,
    output logic [cmd_pkg::byte_w-1:0]  tx_data,
    input  logic                        tx_ready
);

    localparam int bw = cmd_pkg::byte_w;
    localparam int ww = cmd_pkg::word_w;

    logic [ww-1:0]  word_q;
    logic           full;
    logic           hi_sel;

    // take a new word only once both bytes are gone
    assign resp_ready = !full;
    assign tx_valid   = full;
    assign tx_data    = hi_sel ? word_q[ww-1:bw] : word_q[bw-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full   <= 1'b0;
            hi_sel <= 1'b0;
        end else if (resp_valid && resp_ready) begin
            full   <= 1'b1;
            hi_sel <= 1'b0;
        end else if (tx_valid && tx_ready) begin
            if (hi_sel)
                full <= 1'b0;
            else
                hi_sel <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_valid && resp_ready)
            word_q <= resp_data;
    end

    a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

// ==== source/instr_parser_top.sv ====
// Top level of the byte-stream command parser with parser, executor and serializer
`timescale 1ns/1ps

module instr_parser_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // command byte stream
    input  logic                        rx_valid,
    input  logic [cmd_pkg::byte_w-1:0]  rx_data,
    output logic                        rx_ready,
    // read data byte stream
    output logic                        tx_valid,
    output logic [cmd_pkg::byte_w-1:0]  tx_data,
    input  logic                        tx_ready,
    // user registers
    input  logic [cmd_pkg::word_w-1:0]  sum,
    output logic [cmd_pkg::word_w-1:0]  num1,
    output logic [cmd_pkg::word_w-1:0]  num2,
    output logic [cmd_pkg::word_w-1:0]  num3,
    output logic                        en
);

    logic                       resp_valid;
    logic [cmd_pkg::word_w-1:0] resp_data;
    logic                       resp_ready;

    cmd_if u_cmd_if ();

    frame_parser u_parser (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .rx_ready (rx_ready),
        .cmd      (u_cmd_if.source)
    );

    cmd_executor u_exec (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (u_cmd_if.sink),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_ready (resp_ready),
        .sum        (sum),
        .num1       (num1),
        .num2       (num2),
        .num3       (num3),
        .en         (en)
    );

    word_serializer u_ser (
        .clk        (clk),
        .rst_n      (rst_n),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_ready (resp_ready),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .tx_ready   (tx_ready)
    );

endmodule

// ==== tests/resp_checker.sv ====
// Response checker that compares the output byte stream and register outputs with expected values
`timescale 1ns/1ps

module resp_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        tx_valid,
    input  logic [cmd_pkg::byte_w-1:0]  tx_data,
    input  logic                        tx_ready,
    input  logic [cmd_pkg::word_w-1:0]  num1,
    input  logic [cmd_pkg::word_w-1:0]  num2,
    input  logic [cmd_pkg::word_w-1:0]  num3,
    input  logic                        en
);

    logic [cmd_pkg::byte_w-1:0] exp_q [$];
    logic [cmd_pkg::byte_w-1:0] exp_b;
    int                         err_count = 0;
    int                         byte_count = 0;

    function automatic void expect_byte(input logic [cmd_pkg::byte_w-1:0] b);
        exp_q.push_back(b);
    endfunction

    function automatic int pending();
        return exp_q.size();
    endfunction

    function automatic void report_stuck(input string what);
        err_count++;
        $display("timeout while %s, %0d expected bytes never arrived", what, exp_q.size());
    endfunction

    function automatic void check_word(input string name, input logic [cmd_pkg::word_w-1:0] exp_v,
                                       input logic [cmd_pkg::word_w-1:0] got_v);
        if (got_v !== exp_v) begin
            err_count++;
            $display("Error at %0t ns: %s expected 0x%04h, observed 0x%04h",
                     $time, name, exp_v, got_v);
        end
    endfunction

    function automatic void check_outputs(input logic [cmd_pkg::word_w-1:0] exp_num1,
                                          input logic [cmd_pkg::word_w-1:0] exp_num2,
                                          input logic [cmd_pkg::word_w-1:0] exp_num3,
                                          input logic exp_en);
        check_word("num1", exp_num1, num1);
        check_word("num2", exp_num2, num2);
        check_word("num3", exp_num3, num3);
        check_word("en", {15'b0, exp_en}, {15'b0, en});
    endfunction

    // one byte moves per handshake edge
    always @(posedge clk) begin
        if (rst_n && tx_valid && tx_ready) begin
            byte_count++;
            if (exp_q.size() == 0) begin
                err_count++;
                $display("unexpected byte 0x%02h arrived at %0t ns with nothing expected",
                         tx_data, $time);
            end else begin
                exp_b = exp_q.pop_front();
                if (tx_data !== exp_b) begin
                    err_count++;
                    $display("Error at %0t ns: tx_data expected 0x%02h, observed 0x%02h",
                             $time, exp_b, tx_data);
                end
            end
        end
    end

endmodule

// ==== tests/tb_instr_parser.sv ====
// Testbench for the byte-stream command parser with frame driver and reference model
`timescale 1ns/1ps

module tb_instr_parser;

    localparam int wait_limit = 2000;

    logic                       clk;
    logic                       rst_n;
    logic                       rx_valid;
    logic [cmd_pkg::byte_w-1:0] rx_data;
    logic                       rx_ready;
    logic                       tx_valid;
    logic [cmd_pkg::byte_w-1:0] tx_data;
    logic                       tx_ready;
    logic [cmd_pkg::word_w-1:0] sum;
    logic [cmd_pkg::word_w-1:0] num1;
    logic [cmd_pkg::word_w-1:0] num2;
    logic [cmd_pkg::word_w-1:0] num3;
    logic                       en;

    logic [15:0]                bp_lfsr;
    logic [15:0]                data_lfsr;
    logic [cmd_pkg::byte_w-1:0] frame_q [$];
    logic [cmd_pkg::byte_w-1:0] exp_bytes [$];
    logic [cmd_pkg::word_w-1:0] m_ram [cmd_pkg::ram_depth];
    logic [cmd_pkg::word_w-1:0] m_num1;
    logic [cmd_pkg::word_w-1:0] m_num2;
    logic [cmd_pkg::word_w-1:0] m_num3;
    logic                       m_en;
    bit                         aborted;
    int                         test_no;
    int                         tests_failed;
    int                         errs_at_start;

    instr_parser_top u_dut (
        .clk(clk), .rst_n(rst_n),
        .rx_valid(rx_valid), .rx_data(rx_data), .rx_ready(rx_ready),
        .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
        .sum(sum), .num1(num1), .num2(num2), .num3(num3), .en(en)
    );

    resp_checker u_chk (
        .clk(clk), .rst_n(rst_n),
        .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
        .num1(num1), .num2(num2), .num3(num3), .en(en)
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] next_word();
        logic [15:0] w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            data_lfsr = lfsr_step(data_lfsr);
            w = {w[14:0], data_lfsr[0]};
        end
        return w;
    endfunction

    // random back-pressure, one bit per cycle
    always @(negedge clk) begin
        if (rst_n) begin
            bp_lfsr = lfsr_step(bp_lfsr);
            tx_ready = bp_lfsr[0];
        end
    end

    function automatic void push_word(input logic [cmd_pkg::word_w-1:0] w);
        exp_bytes.push_back(w[7:0]);
        exp_bytes.push_back(w[15:8]);
    endfunction

    function automatic logic [cmd_pkg::word_w-1:0] reg_model(input logic [7:0] ra);
        case (ra)
            cmd_pkg::reg_sum:  return sum;
            cmd_pkg::reg_num1: return m_num1;
            cmd_pkg::reg_num2: return m_num2;
            cmd_pkg::reg_num3: return m_num3;
            cmd_pkg::reg_en:   return {15'b0, m_en};
            default:           return '0;
        endcase
    endfunction

    // expected state update and read bytes for the frame in frame_q
    function automatic void model_frame();
        logic [15:0] addr;
        logic [15:0] cnt;
        logic [15:0] d;
        logic [16:0] a;
        exp_bytes.delete();
        case (frame_q[0])
            cmd_pkg::op_disable: m_en = 1'b0;
            cmd_pkg::op_enable:  m_en = 1'b1;
            cmd_pkg::op_write_reg: begin
                d = {frame_q[3], frame_q[2]};
                if (frame_q[1] == cmd_pkg::reg_num1) m_num1 = d;
                if (frame_q[1] == cmd_pkg::reg_num2) m_num2 = d;
                if (frame_q[1] == cmd_pkg::reg_num3) m_num3 = d;
            end
            cmd_pkg::op_read_reg: push_word(reg_model(frame_q[1]));
            cmd_pkg::op_write_ram, cmd_pkg::op_read_ram: begin
                addr = {frame_q[2], frame_q[1]};
                cnt = {frame_q[4], frame_q[3]};
                for (int i = 0; i < int'(cnt); i++) begin
                    a = 17'(addr) + 17'(i);
                    if (frame_q[0] == cmd_pkg::op_write_ram) begin
                        d = {frame_q[6 + 2 * i], frame_q[5 + 2 * i]};
                        if (a < 17'(cmd_pkg::ram_depth))
                            m_ram[a[7:0]] = d;
                    end else begin
                        push_word((a < 17'(cmd_pkg::ram_depth)) ? m_ram[a[7:0]] : 16'h0000);
                    end
                end
            end
            default: ;
        endcase
    endfunction

    // called on a falling edge, returns on a falling edge
    task automatic send_byte(input logic [7:0] b);
        int t;
        if (aborted)
            return;
        rx_valid = 1'b1;
        rx_data = b;
        t = 0;
        while (!rx_ready && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (!rx_ready) begin
            aborted = 1'b1;
            $display("timeout: rx_ready stayed low at %0t ns", $time);
        end else begin
            @(negedge clk);
        end
        rx_valid = 1'b0;
    endtask

    task automatic send_frame();
        model_frame();
        foreach (exp_bytes[i])
            u_chk.expect_byte(exp_bytes[i]);
        foreach (frame_q[i])
            send_byte(frame_q[i]);
    endtask

    task automatic wait_drain(input string what);
        int t;
        if (aborted)
            return;
        t = 0;
        while (u_chk.pending() != 0 && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (u_chk.pending() != 0) begin
            aborted = 1'b1;
            u_chk.report_stuck(what);
        end
    endtask

    task automatic send_op(input logic [7:0] op);
        frame_q.delete();
        frame_q.push_back(op);
        send_frame();
    endtask

    task automatic reg_write(input logic [7:0] ra, input logic [15:0] d);
        frame_q = '{cmd_pkg::op_write_reg, ra, d[7:0], d[15:8]};
        send_frame();
    endtask

    task automatic reg_read(input logic [7:0] ra);
        frame_q = '{cmd_pkg::op_read_reg, ra};
        send_frame();
    endtask

    task automatic ram_write(input logic [15:0] addr, input logic [15:0] cnt);
        logic [15:0] w;
        frame_q = '{cmd_pkg::op_write_ram, addr[7:0], addr[15:8], cnt[7:0], cnt[15:8]};
        for (int i = 0; i < int'(cnt); i++) begin
            w = next_word();
            frame_q.push_back(w[7:0]);
            frame_q.push_back(w[15:8]);
        end
        send_frame();
    endtask

    task automatic ram_read(input logic [15:0] addr, input logic [15:0] cnt);
        frame_q = '{cmd_pkg::op_read_ram, addr[7:0], addr[15:8], cnt[7:0], cnt[15:8]};
        send_frame();
    endtask

    task automatic begin_test();
        test_no++;
        errs_at_start = u_chk.err_count;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = u_chk.err_count - errs_at_start;
        if (aborted || errs != 0) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", test_no, name, errs);
        end else begin
            $display("test %0d %s: ok", test_no, name);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        rx_valid = 1'b0;
        rx_data = '0;
        tx_ready = 1'b1;
        sum = '0;
        bp_lfsr = 16'd6;
        data_lfsr = 16'd6;
        m_en = 1'b0;
        m_num1 = '0;
        m_num2 = '0;
        m_num3 = '0;
        aborted = 1'b0;
        test_no = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        begin_test();
        send_op(cmd_pkg::op_enable);
        reg_read(cmd_pkg::reg_en);
        wait_drain("reading the enable flag");
        u_chk.check_outputs(m_num1, m_num2, m_num3, m_en);
        send_op(cmd_pkg::op_disable);
        reg_read(cmd_pkg::reg_en);
        wait_drain("reading the enable flag");
        u_chk.check_outputs(m_num1, m_num2, m_num3, m_en);
        end_test("enable and disable");

        begin_test();
        reg_write(cmd_pkg::reg_num1, next_word());
        reg_write(cmd_pkg::reg_num2, next_word());
        reg_write(cmd_pkg::reg_num3, next_word());
        reg_read(cmd_pkg::reg_num1);
        reg_read(cmd_pkg::reg_num2);
        reg_read(cmd_pkg::reg_num3);
        wait_drain("reading num1 to num3");
        u_chk.check_outputs(m_num1, m_num2, m_num3, m_en);
        end_test("register write and read");

        begin_test();
        sum = next_word();
        reg_read(cmd_pkg::reg_sum);
        reg_read(8'd9);
        wait_drain("reading sum and address 9");
        end_test("sum input and unknown address");

        begin_test();
        ram_write(16'd20, 16'd8);
        ram_read(16'd20, 16'd8);
        wait_drain("reading the RAM block at 20");
        end_test("RAM block round trip");

        begin_test();
        ram_write(16'd252, 16'd8);
        ram_read(16'd252, 16'd8);
        ram_write(16'd40, 16'd0);
        ram_read(16'd40, 16'd0);
        reg_read(cmd_pkg::reg_num2);
        wait_drain("reading the block across 255");
        end_test("RAM range limit and empty blocks");

        // address of the second read differs from the read opcode value
        begin_test();
        reg_read(cmd_pkg::reg_num1);
        send_op(8'd4);
        reg_read(cmd_pkg::reg_num2);
        wait_drain("reading around an unknown opcode");
        u_chk.check_outputs(m_num1, m_num2, m_num3, m_en);
        end_test("unknown opcode");

        $display("summary: %0d tests, %0d failed, %0d bytes checked, %0d errors",
                 test_no, tests_failed, u_chk.byte_count, u_chk.err_count);
        if (aborted || tests_failed != 0 || u_chk.err_count != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

// ==== files.f ====
source/cmd_pkg.sv
source/cmd_if.sv
source/word_ram.sv
source/frame_parser.sv
source/cmd_executor.sv
source/word_serializer.sv
source/instr_parser_top.sv
tests/resp_checker.sv
tests/tb_instr_parser.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f files.f \
    --top-module tb_instr_parser \
    -Mdir obj_dir -o sim_instr_parser

./obj_dir/sim_instr_parser | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
